//--- src/conv_defines.svh
`ifndef CONV_DEFINES_SVH
`define CONV_DEFINES_SVH

// Data path widths
`define CONV_PIXEL_WIDTH    16
// Room for nine 32-bit products plus the bias
`define CONV_ACC_WIDTH      36

// Image geometry and counters
`define CONV_IMAGE_WIDTH    8
`define CONV_IMAGE_HEIGHT   8
`define CONV_KERNEL         3
`define CONV_COL_BITS       3
`define CONV_ROW_BITS       3

// APB register map
`define CONV_APB_ADDR_WIDTH 8
`define CONV_REG_CTRL       8'h00
`define CONV_REG_BIAS       8'h04
`define CONV_REG_STATUS     8'h08
`define CONV_REG_WEIGHT0    8'h10

`endif

//--- src/conv_pkg.sv
`default_nettype none

`include "conv_defines.svh"

package conv_pkg;

	//////////////////////////////////////////////////
	// Data path types

	// One image sample
	typedef logic signed [`CONV_PIXEL_WIDTH-1:0] pixel_t;

	// Kernel coefficient, same width as a pixel
	typedef logic signed [`CONV_PIXEL_WIDTH-1:0] weight_t;

	// Full product of a pixel and a weight
	typedef logic signed [2*`CONV_PIXEL_WIDTH-1:0] prod_t;

	// Accumulated window result
	typedef logic signed [`CONV_ACC_WIDTH-1:0] acc_t;

	//////////////////////////////////////////////////
	// Register bus

	typedef logic [31:0] apb_data_t;

endpackage

`default_nettype wire

//--- src/line_buffer.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_defines.svh"

// Delay line between two rows of the window
// Advances only on accepted pixels, so gaps in the stream are harmless
module line_buffer #(
	parameter int DEPTH = `CONV_IMAGE_WIDTH - `CONV_KERNEL
) (
	input  wire                   clk,
	input  wire                   reset,
	input  wire                   shift_en,
	input  wire conv_pkg::pixel_t data_in,
	output conv_pkg::pixel_t      data_out
);

	conv_pkg::pixel_t chain [DEPTH];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < DEPTH; i++) begin
				chain[i] <= '0;
			end
		end else if (shift_en) begin
			chain[0] <= data_in;
			for (int i = 1; i < DEPTH; i++) begin
				chain[i] <= chain[i-1];
			end
		end
	end

	// Oldest entry
	assign data_out = chain[DEPTH-1];

endmodule

`default_nettype wire

//--- src/window_buffer.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_defines.svh"

// 3x3 window over a row-major pixel stream
// win_08 holds the newest pixel, win_00 the top-left of the window
module window_buffer (
	input  wire                   clk,
	input  wire                   reset,
	input  wire                   pixel_valid,
	input  wire conv_pkg::pixel_t pixel_data,
	input  wire                   stride2,
	output conv_pkg::pixel_t      win_00,
	output conv_pkg::pixel_t      win_01,
	output conv_pkg::pixel_t      win_02,
	output conv_pkg::pixel_t      win_03,
	output conv_pkg::pixel_t      win_04,
	output conv_pkg::pixel_t      win_05,
	output conv_pkg::pixel_t      win_06,
	output conv_pkg::pixel_t      win_07,
	output conv_pkg::pixel_t      win_08,
	output logic                  window_valid,
	output logic                  load_weights,
	output logic                  frame_done
);

	localparam int COL_BITS = `CONV_COL_BITS;
	localparam int ROW_BITS = `CONV_ROW_BITS;
	localparam int LB_DEPTH = `CONV_IMAGE_WIDTH - `CONV_KERNEL;

	localparam logic [COL_BITS-1:0] LAST_COL = COL_BITS'(`CONV_IMAGE_WIDTH - 1);
	localparam logic [ROW_BITS-1:0] LAST_ROW = ROW_BITS'(`CONV_IMAGE_HEIGHT - 1);
	// Position of the bottom-right pixel of the first full window
	localparam logic [COL_BITS-1:0] WIN_COL0 = COL_BITS'(`CONV_KERNEL - 1);
	localparam logic [ROW_BITS-1:0] WIN_ROW0 = ROW_BITS'(`CONV_KERNEL - 1);

	logic [COL_BITS-1:0] col_cnt;
	logic [ROW_BITS-1:0] row_cnt;
	logic [COL_BITS-1:0] origin_col;
	logic [ROW_BITS-1:0] origin_row;
	logic                last_col;
	logic                last_row;
	logic                win_inside;
	logic                win_stride_ok;
	conv_pkg::pixel_t    mid_tap;
	conv_pkg::pixel_t    top_tap;

	//////////////////////////////////////////////////
	// Window shift stages

	// Bottom row to middle row
	line_buffer #(.DEPTH(LB_DEPTH)) lb_mid (
		.clk     (clk),
		.reset   (reset),
		.shift_en(pixel_valid),
		.data_in (win_06),
		.data_out(mid_tap)
	);

	// Middle row to top row
	line_buffer #(.DEPTH(LB_DEPTH)) lb_top (
		.clk     (clk),
		.reset   (reset),
		.shift_en(pixel_valid),
		.data_in (win_03),
		.data_out(top_tap)
	);

	always_ff @(posedge clk) begin
		if (pixel_valid) begin
			win_08 <= pixel_data;
			win_07 <= win_08;
			win_06 <= win_07;
			win_05 <= mid_tap;
			win_04 <= win_05;
			win_03 <= win_04;
			win_02 <= top_tap;
			win_01 <= win_02;
			win_00 <= win_01;
		end
	end

	//////////////////////////////////////////////////
	// Position of the incoming pixel

	assign last_col = col_cnt == LAST_COL;
	assign last_row = row_cnt == LAST_ROW;

	always_ff @(posedge clk) begin
		if (reset) begin
			col_cnt <= '0;
			row_cnt <= '0;
		end else if (pixel_valid) begin
			if (last_col) begin
				col_cnt <= '0;
				row_cnt <= last_row ? '0 : row_cnt + 1'b1;
			end else begin
				col_cnt <= col_cnt + 1'b1;
			end
		end
	end

	//////////////////////////////////////////////////
	// Window qualification

	assign origin_col    = col_cnt - WIN_COL0;
	assign origin_row    = row_cnt - WIN_ROW0;
	assign win_inside    = (col_cnt >= WIN_COL0) && (row_cnt >= WIN_ROW0);
	// Stride 2 keeps even origins only
	assign win_stride_ok = !stride2 || (!origin_col[0] && !origin_row[0]);

	always_ff @(posedge clk) begin
		if (reset) begin
			window_valid <= 1'b0;
			load_weights <= 1'b0;
			frame_done   <= 1'b0;
		end else begin
			window_valid <= pixel_valid && win_inside && win_stride_ok;
			load_weights <= pixel_valid && (col_cnt == '0) && (row_cnt == '0);
			frame_done   <= pixel_valid && last_col && last_row;
		end
	end

	// Working stride only moves right after the frame start strobe
	stride_fixed_in_frame: assert property (@(posedge clk) disable iff (reset)
		stride2 != $past(stride2) |-> $past(load_weights))
		else $error("stride2 changed in the middle of a frame");

	// Each window needs its own accepted pixel
	one_window_per_pixel: assert property (@(posedge clk) disable iff (reset)
		window_valid && !pixel_valid |=> !window_valid)
		else $error("window_valid repeated without a new pixel");

endmodule

`default_nettype wire

//--- src/conv_mac.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_defines.svh"

// Two-stage dot product of a 3x3 window with the kernel, plus bias
module conv_mac (
	input  wire                    clk,
	input  wire                    reset,
	input  wire                    window_valid,
	input  wire conv_pkg::pixel_t  win_00,
	input  wire conv_pkg::pixel_t  win_01,
	input  wire conv_pkg::pixel_t  win_02,
	input  wire conv_pkg::pixel_t  win_03,
	input  wire conv_pkg::pixel_t  win_04,
	input  wire conv_pkg::pixel_t  win_05,
	input  wire conv_pkg::pixel_t  win_06,
	input  wire conv_pkg::pixel_t  win_07,
	input  wire conv_pkg::pixel_t  win_08,
	input  wire conv_pkg::weight_t weight_0,
	input  wire conv_pkg::weight_t weight_1,
	input  wire conv_pkg::weight_t weight_2,
	input  wire conv_pkg::weight_t weight_3,
	input  wire conv_pkg::weight_t weight_4,
	input  wire conv_pkg::weight_t weight_5,
	input  wire conv_pkg::weight_t weight_6,
	input  wire conv_pkg::weight_t weight_7,
	input  wire conv_pkg::weight_t weight_8,
	input  wire conv_pkg::acc_t    bias,
	output logic                   result_valid,
	output conv_pkg::acc_t         result_data
);

	localparam int NUM_TAPS = `CONV_KERNEL * `CONV_KERNEL;

	conv_pkg::pixel_t  win  [NUM_TAPS];
	conv_pkg::weight_t coef [NUM_TAPS];
	conv_pkg::prod_t   prod [NUM_TAPS];
	logic              prod_valid;
	conv_pkg::acc_t    sum;

	assign win[0]  = win_00;
	assign win[1]  = win_01;
	assign win[2]  = win_02;
	assign win[3]  = win_03;
	assign win[4]  = win_04;
	assign win[5]  = win_05;
	assign win[6]  = win_06;
	assign win[7]  = win_07;
	assign win[8]  = win_08;
	assign coef[0] = weight_0;
	assign coef[1] = weight_1;
	assign coef[2] = weight_2;
	assign coef[3] = weight_3;
	assign coef[4] = weight_4;
	assign coef[5] = weight_5;
	assign coef[6] = weight_6;
	assign coef[7] = weight_7;
	assign coef[8] = weight_8;

	//////////////////////////////////////////////////
	// Stage one, products

	always_ff @(posedge clk) begin
		if (window_valid) begin
			for (int k = 0; k < NUM_TAPS; k++) begin
				prod[k] <= conv_pkg::prod_t'(win[k]) * conv_pkg::prod_t'(coef[k]);
			end
		end
	end

	//////////////////////////////////////////////////
	// Stage two, adder tree and bias

	always_comb begin
		sum = bias;
		for (int k = 0; k < NUM_TAPS; k++) begin
			sum = sum + conv_pkg::acc_t'(prod[k]);
		end
	end

	always_ff @(posedge clk) begin
		if (prod_valid) begin
			result_data <= sum;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			prod_valid   <= 1'b0;
			result_valid <= 1'b0;
		end else begin
			prod_valid   <= window_valid;
			result_valid <= prod_valid;
		end
	end

	fixed_latency: assert property (@(posedge clk) disable iff (reset)
		result_valid == $past(window_valid, 2))
		else $error("result_valid is not window_valid delayed by two cycles");

endmodule

`default_nettype wire

//--- src/conv_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_defines.svh"

// APB register block with per-frame working copies of the kernel
module conv_regs (
	input  wire                            clk,
	input  wire                            reset,
	input  wire                            psel,
	input  wire                            penable,
	input  wire                            pwrite,
	input  wire [`CONV_APB_ADDR_WIDTH-1:0] paddr,
	input  wire conv_pkg::apb_data_t       pwdata,
	output conv_pkg::apb_data_t            prdata,
	output logic                           pready,
	output logic                           pslverr,
	input  wire                            load_weights,
	input  wire                            result_valid,
	input  wire                            frame_done,
	output logic                           stride2,
	output conv_pkg::weight_t              weight_0,
	output conv_pkg::weight_t              weight_1,
	output conv_pkg::weight_t              weight_2,
	output conv_pkg::weight_t              weight_3,
	output conv_pkg::weight_t              weight_4,
	output conv_pkg::weight_t              weight_5,
	output conv_pkg::weight_t              weight_6,
	output conv_pkg::weight_t              weight_7,
	output conv_pkg::weight_t              weight_8,
	output conv_pkg::acc_t                 bias
);

	localparam int NUM_WEIGHTS = `CONV_KERNEL * `CONV_KERNEL;
	localparam int ADDR_W      = `CONV_APB_ADDR_WIDTH;

	localparam logic [ADDR_W-1:0] WEIGHT_FIRST = `CONV_REG_WEIGHT0;
	localparam logic [ADDR_W-1:0] WEIGHT_LAST  =
		ADDR_W'(`CONV_REG_WEIGHT0 + 4 * (NUM_WEIGHTS - 1));

	// Programmed values
	logic              ctrl_stride2;
	conv_pkg::weight_t bias_reg;
	conv_pkg::weight_t weight_reg [NUM_WEIGHTS];
	logic [15:0]       result_count;
	logic              frame_done_flag;
	// Values used by the running frame
	conv_pkg::weight_t weight_work [NUM_WEIGHTS];

	logic              wr_en;
	logic              hit_ctrl;
	logic              hit_bias;
	logic              hit_status;
	logic              hit_weight;
	logic [ADDR_W-1:0] weight_off;
	logic [3:0]        weight_idx;

	//////////////////////////////////////////////////
	// Address decode

	assign hit_ctrl   = paddr == `CONV_REG_CTRL;
	assign hit_bias   = paddr == `CONV_REG_BIAS;
	assign hit_status = paddr == `CONV_REG_STATUS;
	assign hit_weight = (paddr >= WEIGHT_FIRST) && (paddr <= WEIGHT_LAST) &&
		(paddr[1:0] == 2'b00);
	assign weight_off = paddr - WEIGHT_FIRST;
	assign weight_idx = weight_off[5:2];

	assign wr_en   = psel && penable && pwrite;
	assign pready  = 1'b1;
	assign pslverr = psel && penable &&
		!(hit_ctrl || hit_bias || hit_status || hit_weight);

	always_comb begin
		prdata = '0;
		if (hit_ctrl)
			prdata = {31'b0, ctrl_stride2};
		else if (hit_bias)
			prdata = conv_pkg::apb_data_t'(bias_reg);
		else if (hit_status)
			prdata = {15'b0, frame_done_flag, result_count};
		else if (hit_weight)
			prdata = conv_pkg::apb_data_t'(weight_reg[weight_idx]);
	end

	//////////////////////////////////////////////////
	// Register writes and status

	always_ff @(posedge clk) begin
		if (reset) begin
			ctrl_stride2 <= 1'b0;
			bias_reg     <= '0;
			for (int k = 0; k < NUM_WEIGHTS; k++) begin
				weight_reg[k] <= '0;
			end
		end else if (wr_en) begin
			if (hit_ctrl)
				ctrl_stride2 <= pwdata[0];
			if (hit_bias)
				bias_reg <= pwdata[15:0];
			if (hit_weight)
				weight_reg[weight_idx] <= pwdata[15:0];
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			result_count    <= '0;
			frame_done_flag <= 1'b0;
		end else begin
			if (result_valid)
				result_count <= result_count + 1'b1;
			// A new frame_done wins over a clear in the same cycle
			if (frame_done)
				frame_done_flag <= 1'b1;
			else if (wr_en && hit_status && pwdata[16])
				frame_done_flag <= 1'b0;
		end
	end

	//////////////////////////////////////////////////
	// Snapshot at frame start

	always_ff @(posedge clk) begin
		if (reset) begin
			stride2 <= 1'b0;
			bias    <= '0;
			for (int k = 0; k < NUM_WEIGHTS; k++) begin
				weight_work[k] <= '0;
			end
		end else if (load_weights) begin
			stride2 <= ctrl_stride2;
			bias    <= conv_pkg::acc_t'(bias_reg);
			for (int k = 0; k < NUM_WEIGHTS; k++) begin
				weight_work[k] <= weight_reg[k];
			end
		end
	end

	assign weight_0 = weight_work[0];
	assign weight_1 = weight_work[1];
	assign weight_2 = weight_work[2];
	assign weight_3 = weight_work[3];
	assign weight_4 = weight_work[4];
	assign weight_5 = weight_work[5];
	assign weight_6 = weight_work[6];
	assign weight_7 = weight_work[7];
	assign weight_8 = weight_work[8];

	// Error response only in the access phase
	slverr_in_access: assert property (@(posedge clk) disable iff (reset)
		pslverr |-> psel && penable)
		else $error("pslverr outside an access phase");

endmodule

`default_nettype wire

//--- src/conv_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_defines.svh"

// Streaming 3x3 convolution engine
module conv_top (
	input  wire                            clk,
	input  wire                            reset,
	input  wire                            psel,
	input  wire                            penable,
	input  wire                            pwrite,
	input  wire [`CONV_APB_ADDR_WIDTH-1:0] paddr,
	input  wire conv_pkg::apb_data_t       pwdata,
	output conv_pkg::apb_data_t            prdata,
	output logic                           pready,
	output logic                           pslverr,
	input  wire                            pixel_valid,
	input  wire conv_pkg::pixel_t          pixel_data,
	output logic                           result_valid,
	output conv_pkg::acc_t                 result_data
);

	// Frame control
	logic              stride2;
	logic              load_weights;
	logic              frame_done;
	logic              window_valid;

	// Current window
	conv_pkg::pixel_t  win_00;
	conv_pkg::pixel_t  win_01;
	conv_pkg::pixel_t  win_02;
	conv_pkg::pixel_t  win_03;
	conv_pkg::pixel_t  win_04;
	conv_pkg::pixel_t  win_05;
	conv_pkg::pixel_t  win_06;
	conv_pkg::pixel_t  win_07;
	conv_pkg::pixel_t  win_08;

	// Working kernel of the running frame
	conv_pkg::weight_t weight_0;
	conv_pkg::weight_t weight_1;
	conv_pkg::weight_t weight_2;
	conv_pkg::weight_t weight_3;
	conv_pkg::weight_t weight_4;
	conv_pkg::weight_t weight_5;
	conv_pkg::weight_t weight_6;
	conv_pkg::weight_t weight_7;
	conv_pkg::weight_t weight_8;
	conv_pkg::acc_t    bias;

	conv_regs regs0 (.*);

	window_buffer win_buf0 (.*);

	conv_mac mac0 (.*);

endmodule

`default_nettype wire

//--- testbench/conv_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_defines.svh"

module conv_tb;

	localparam int WIDTH          = `CONV_IMAGE_WIDTH;
	localparam int HEIGHT         = `CONV_IMAGE_HEIGHT;
	localparam int KERNEL         = `CONV_KERNEL;
	localparam int NUM_WEIGHTS    = `CONV_KERNEL * `CONV_KERNEL;
	// Four frames of at most 128 cycles plus APB traffic, with margin
	localparam int TIMEOUT_CYCLES = 4000;
	// Cycles from the accepted bottom-right pixel to its result
	localparam int RESULT_LATENCY = 3;

	localparam logic [7:0] ADDR_CTRL   = `CONV_REG_CTRL;
	localparam logic [7:0] ADDR_BIAS   = `CONV_REG_BIAS;
	localparam logic [7:0] ADDR_STATUS = `CONV_REG_STATUS;

	logic                     clk = 1'b0;
	logic                     reset;
	logic                     psel;
	logic                     penable;
	logic                     pwrite;
	logic [7:0]               paddr;
	logic [31:0]              pwdata;
	logic [31:0]              prdata;
	logic                     pready;
	logic                     pslverr;
	logic                     pixel_valid;
	conv_pkg::pixel_t         pixel_data;
	logic                     result_valid;
	conv_pkg::acc_t           result_data;

	// Reference model state
	logic [31:0]              rng_state = 32'h5227;
	conv_pkg::pixel_t         image [HEIGHT][WIDTH];
	conv_pkg::weight_t        prog_weight [NUM_WEIGHTS];
	conv_pkg::weight_t        prog_bias;
	logic                     prog_stride;
	conv_pkg::acc_t           expected_q [$];
	int                       expected_total = 0;
	int                       results_seen = 0;
	int                       pixels_sent = 0;
	int                       cycle_count = 0;
	logic                     head_present = 1'b0;
	conv_pkg::acc_t           head_value = '0;

	conv_top dut0 (.*);

	always #2 clk = ~clk;

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			stop_with_failure();
		end
	end

	//////////////////////////////////////////////////
	// Result checking

	// Fetch the expected head mid-cycle, checked at the next rising edge
	always @(negedge clk) begin
		if (!reset && result_valid) begin
			head_present = expected_q.size() != 0;
			head_value   = head_present ? expected_q.pop_front() : '0;
			results_seen++;
		end
	end

	result_expected: assert property (@(posedge clk) disable iff (reset)
		result_valid |-> head_present)
		else begin
			$display("A result appeared when none was expected");
			stop_with_failure();
		end

	result_matches: assert property (@(posedge clk) disable iff (reset)
		result_valid && head_present |-> result_data == head_value)
		else begin
			$display("FAILED result_data=%h expected=%h", $sampled(result_data),
				$sampled(head_value));
			stop_with_failure();
		end

	task automatic stop_with_failure();
		$display("TESTBENCH FAILED");
		$fatal(1, "Simulation stopped on the first error");
	endtask

	function logic [31:0] next_rand();
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		return rng_state;
	endfunction

	//////////////////////////////////////////////////
	// APB transfers

	// Slave response in the access phase
	task automatic check_access_phase(input logic [7:0] addr, input logic expect_err);
		assert (pready) else begin
			$display("FAILED pready=%h expected=1 paddr=%h", pready, addr);
			stop_with_failure();
		end
		assert (pslverr == expect_err) else begin
			$display("FAILED pslverr=%h expected=%h paddr=%h", pslverr, expect_err, addr);
			stop_with_failure();
		end
	endtask

	task automatic apb_write(input logic [7:0] addr, input logic [31:0] data,
			input logic expect_err);
		@(posedge clk);
		psel    <= 1'b1;
		penable <= 1'b0;
		pwrite  <= 1'b1;
		paddr   <= addr;
		pwdata  <= data;
		@(posedge clk);
		penable <= 1'b1;
		@(negedge clk);
		check_access_phase(addr, expect_err);
		@(posedge clk);
		psel    <= 1'b0;
		penable <= 1'b0;
		pwrite  <= 1'b0;
	endtask

	task automatic apb_read_check(input logic [7:0] addr, input logic [31:0] expected,
			input logic expect_err);
		@(posedge clk);
		psel    <= 1'b1;
		penable <= 1'b0;
		pwrite  <= 1'b0;
		paddr   <= addr;
		@(posedge clk);
		penable <= 1'b1;
		@(negedge clk);
		check_access_phase(addr, expect_err);
		assert (prdata == expected) else begin
			$display("FAILED prdata=%h expected=%h paddr=%h", prdata, expected, addr);
			stop_with_failure();
		end
		@(posedge clk);
		psel    <= 1'b0;
		penable <= 1'b0;
	endtask

	// Random kernel, upper halves of the write data carry junk
	task automatic program_kernel();
		logic [31:0] r;
		for (int k = 0; k < NUM_WEIGHTS; k++) begin
			r = next_rand();
			prog_weight[k] = r[31:16];
			apb_write(8'(`CONV_REG_WEIGHT0 + 4 * k), {r[15:0], r[31:16]}, 1'b0);
		end
		r = next_rand();
		prog_bias = r[31:16];
		apb_write(ADDR_BIAS, {r[15:0], r[31:16]}, 1'b0);
	endtask

	task automatic set_stride(input logic stride2);
		prog_stride = stride2;
		apb_write(ADDR_CTRL, {31'b0, stride2}, 1'b0);
	endtask

	task automatic check_status();
		logic [31:0] count_field;
		count_field = {16'b0, 16'(expected_total)};
		apb_read_check(ADDR_STATUS, count_field | 32'h0001_0000, 1'b0);
		apb_write(ADDR_STATUS, 32'h0001_0000, 1'b0);
		apb_read_check(ADDR_STATUS, count_field, 1'b0);
	endtask

	//////////////////////////////////////////////////
	// Frames

	task automatic fill_image();
		logic [31:0] r;
		for (int row = 0; row < HEIGHT; row++) begin
			for (int col = 0; col < WIDTH; col++) begin
				r = next_rand();
				image[row][col] = r[31:16];
			end
		end
	endtask

	// Window origins in raster order, dot product plus bias
	task automatic push_expected();
		int     step;
		longint sum;
		step = prog_stride ? 2 : 1;
		for (int r = 0; r + KERNEL <= HEIGHT; r += step) begin
			for (int c = 0; c + KERNEL <= WIDTH; c += step) begin
				sum = longint'(prog_bias);
				for (int i = 0; i < KERNEL; i++) begin
					for (int j = 0; j < KERNEL; j++) begin
						sum += longint'(image[r+i][c+j]) * longint'(prog_weight[i*KERNEL+j]);
					end
				end
				expected_q.push_back(conv_pkg::acc_t'(sum));
				expected_total++;
			end
		end
	endtask

	task automatic send_frame();
		logic [31:0] r;
		for (int row = 0; row < HEIGHT; row++) begin
			for (int col = 0; col < WIDTH; col++) begin
				r = next_rand();
				// Occasional idle cycles
				while (r[31:29] == 3'd0) begin
					@(posedge clk);
					pixel_valid <= 1'b0;
					r = next_rand();
				end
				@(posedge clk);
				pixel_valid <= 1'b1;
				pixel_data  <= image[row][col];
				pixels_sent++;
			end
		end
		@(posedge clk);
		pixel_valid <= 1'b0;
	endtask

	// Last result of a frame is due a fixed latency after its last pixel
	task automatic drain_results();
		repeat (RESULT_LATENCY + 1) @(posedge clk);
	endtask

	// A positive rewrite_at reprograms the kernel after that many pixels
	task automatic run_frame(input int rewrite_at);
		int step;
		int out_rows;
		int out_cols;
		int seen_before;
		step        = prog_stride ? 2 : 1;
		out_rows    = (HEIGHT - KERNEL) / step + 1;
		out_cols    = (WIDTH - KERNEL) / step + 1;
		seen_before = results_seen;
		pixels_sent = 0;
		fill_image();
		push_expected();
		fork
			send_frame();
			begin
				if (rewrite_at > 0) begin
					while (pixels_sent < rewrite_at) begin
						@(posedge clk);
					end
					program_kernel();
				end
			end
		join
		drain_results();
		assert (results_seen - seen_before == out_rows * out_cols) else begin
			$display("Frame produced %0d results instead of %0d",
				results_seen - seen_before, out_rows * out_cols);
			stop_with_failure();
		end
		check_status();
	endtask

	//////////////////////////////////////////////////
	// Test sequence

	initial begin
		reset       = 1'b1;
		psel        = 1'b0;
		penable     = 1'b0;
		pwrite      = 1'b0;
		paddr       = '0;
		pwdata      = '0;
		pixel_valid = 1'b0;
		pixel_data  = '0;
		prog_stride = 1'b0;
		prog_bias   = '0;
		repeat (2) @(posedge clk);
		reset <= 1'b0;
		@(posedge clk);

		// Reset values
		apb_read_check(ADDR_STATUS, 32'h0, 1'b0);
		apb_read_check(ADDR_CTRL, 32'h0, 1'b0);

		// Register read-back, weights and bias sign-extended
		set_stride(1'b1);
		program_kernel();
		apb_read_check(ADDR_CTRL, 32'h1, 1'b0);
		apb_read_check(ADDR_BIAS, {{16{prog_bias[15]}}, prog_bias}, 1'b0);
		for (int k = 0; k < NUM_WEIGHTS; k++) begin
			apb_read_check(8'(`CONV_REG_WEIGHT0 + 4 * k),
				{{16{prog_weight[k][15]}}, prog_weight[k]}, 1'b0);
		end

		// Unmapped addresses
		apb_read_check(8'h0C, 32'h0, 1'b1);
		apb_read_check(8'h12, 32'h0, 1'b1);
		apb_read_check(8'h34, 32'h0, 1'b1);
		apb_write(8'h0C, 32'hFFFF_FFFF, 1'b1);
		apb_read_check(ADDR_CTRL, 32'h1, 1'b0);
		apb_read_check(ADDR_BIAS, {{16{prog_bias[15]}}, prog_bias}, 1'b0);

		// Stride 1 frame
		set_stride(1'b0);
		program_kernel();
		run_frame(0);

		// Stride 2 frame
		set_stride(1'b1);
		program_kernel();
		run_frame(0);

		// Kernel rewritten mid-frame, then a frame with the new kernel
		set_stride(1'b0);
		program_kernel();
		run_frame(20);
		run_frame(0);

		if (expected_q.size() == 0 && results_seen == expected_total) begin
			$display("TESTBENCH PASSED");
			$finish;
		end else begin
			$display("Results incomplete: %0d seen, %0d expected", results_seen,
				expected_total);
			stop_with_failure();
		end
	end

endmodule

`default_nettype wire

//--- conv_engine.f
+incdir+src
src/conv_pkg.sv
src/line_buffer.sv
src/window_buffer.sv
src/conv_mac.sv
src/conv_regs.sv
src/conv_top.sv
testbench/conv_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the conv_engine testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f conv_engine.f --top-module conv_tb -o conv_tb

status=0
output=$(./obj_dir/conv_tb 2>&1) || status=$?
printf '%s\n' "$output"

if [ "$status" -eq 0 ] && printf '%s\n' "$output" | grep -q "TESTBENCH PASSED"; then
	exit 0
fi
exit 1
